/* logic/xm23_pkg.sv */
`default_nettype none

package xm23_pkg;

	// Micro-operation kinds issued by the sequencer
	typedef enum logic [2:0] {
		UOP_NOP,
		UOP_ALU,
		UOP_MOVE,
		UOP_IMM,
		UOP_SXT,
		UOP_LD_MAR,
		UOP_LD,
		UOP_ST
	} xm23_uop_e;

	typedef enum logic [3:0] {
		ADD, ADDC, SUB, SUBC, CMP,	// Arithmetic group
		XOR, AND, OR, BIT, BIC, BIS	// Logical group
	} xm23_alu_op_e;

	typedef enum logic [1:0] {
		MOVL,
		MOVLZ,
		MOVLS,
		MOVH
	} xm23_imm_op_e;

	typedef struct packed {
		logic [2:0]   rsvd;		// Pads to a 32-bit word
		xm23_uop_e    kind;
		xm23_alu_op_e alu_op;
		xm23_imm_op_e imm_op;
		logic [2:0]   dst;
		logic [3:0]   src;		// 8 to 15 pick a constant
		logic         byte_mode;
		logic [7:0]   imm_byte;
		logic [3:0]   sxt_bit;
	} xm23_uop_t;

	typedef struct packed {
		logic        rd;
		logic        we;
		logic        byte_mode;
		logic [3:0]  addr;
		logic [15:0] wdata;
	} xm23_dev_req_t;

	// Device byte addresses
	localparam logic [3:0] TMR_CSR  = 4'd0;
	localparam logic [3:0] TMR_DATA = 4'd1;
	localparam logic [3:0] TL_CSR   = 4'd6;
	localparam logic [3:0] TL_DATA  = 4'd7;
	localparam logic [3:0] PB_CSR   = 4'd8;
	localparam logic [3:0] PB_DATA  = 4'd9;

	localparam int PSW_C = 0;
	localparam int PSW_Z = 1;
	localparam int PSW_N = 2;
	localparam int PSW_V = 4;

	localparam int CSR_EN  = 0;
	localparam int CSR_DBA = 2;	// Data available
	localparam int CSR_OF  = 3;	// Overflow, DBA was still pending

	localparam logic [15:0] PSW_RESET = 16'h60e0;

endpackage

`default_nettype wire

/* logic/xm23_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module xm23_alu (
	input  xm23_pkg::xm23_alu_op_e alu_op_i,
	input  logic                   byte_mode_i,
	input  logic [15:0]            dst_i,
	input  logic [15:0]            src_i,
	input  logic [15:0]            psw_i,
	output logic [15:0]            result_o,
	output logic [15:0]            psw_o
);
	import xm23_pkg::*;

	logic [15:0] opnd_b;	// Source as seen by the adder
	logic        cin;
	logic        is_arith;
	logic [16:0] sum_w;
	logic [8:0]  sum_b;
	logic [15:0] raw;
	logic        msb_a;
	logic        msb_b;
	logic        msb_r;

	// Subtraction is dst + ~src + 1 (or + C)
	always_comb begin
		opnd_b   = src_i;
		cin      = 1'b0;
		is_arith = 1'b1;
		case (alu_op_i)
			ADD: cin = 1'b0;
			ADDC: cin = psw_i[PSW_C];
			SUB, CMP: begin
				opnd_b = ~src_i;
				cin    = 1'b1;
			end
			SUBC: begin
				opnd_b = ~src_i;
				cin    = psw_i[PSW_C];
			end
			default: is_arith = 1'b0;
		endcase
	end

	assign sum_w = {1'b0, dst_i} + {1'b0, opnd_b} + 17'(cin);
	assign sum_b = {1'b0, dst_i[7:0]} + {1'b0, opnd_b[7:0]} + 9'(cin);	// Byte carry out of bit 7

	always_comb begin
		case (alu_op_i)
			XOR: raw = dst_i ^ src_i;
			AND, BIT: raw = dst_i & src_i;
			OR, BIS: raw = dst_i | src_i;
			BIC: raw = dst_i & ~src_i;
			default: raw = sum_w[15:0];
		endcase
	end

	assign msb_a = byte_mode_i ? dst_i[7] : dst_i[15];
	assign msb_b = byte_mode_i ? opnd_b[7] : opnd_b[15];
	assign msb_r = byte_mode_i ? raw[7] : raw[15];

	// High byte of dst survives a byte op
	assign result_o = byte_mode_i ? {dst_i[15:8], raw[7:0]} : raw;

	always_comb begin
		psw_o        = psw_i;
		psw_o[PSW_Z] = byte_mode_i ? (raw[7:0] == 8'h00) : (raw == 16'h0000);
		psw_o[PSW_N] = msb_r;
		psw_o[PSW_V] = is_arith && (msb_a == msb_b) && (msb_r != msb_a);
		if (is_arith)
			psw_o[PSW_C] = byte_mode_i ? sum_b[8] : sum_w[16];	// Logical ops keep C
	end

endmodule

`default_nettype wire

/* logic/xm23_byte_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module xm23_byte_unit (
	input  xm23_pkg::xm23_uop_t uop_i,
	input  logic [15:0]         reg_i,
	output logic [15:0]         result_o
);
	import xm23_pkg::*;

	logic [15:0] imm_res;
	logic [15:0] sxt_res;

	// Immediate byte moves on the destination value
	always_comb begin
		case (uop_i.imm_op)
			MOVL: imm_res = {reg_i[15:8], uop_i.imm_byte};
			MOVLZ: imm_res = {8'h00, uop_i.imm_byte};
			MOVLS: imm_res = {8'hff, uop_i.imm_byte};
			default: imm_res = {uop_i.imm_byte, reg_i[7:0]};	// MOVH
		endcase
	end

	// Bits above sxt_bit copy the sign bit
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			if (i > int'(uop_i.sxt_bit))
				sxt_res[i] = reg_i[uop_i.sxt_bit];
			else
				sxt_res[i] = reg_i[i];
		end
	end

	always_comb begin
		case (uop_i.kind)
			UOP_SXT: result_o = sxt_res;
			UOP_IMM: result_o = imm_res;
			default: result_o = reg_i;
		endcase
	end

endmodule

`default_nettype wire

/* logic/xm23_dev_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module xm23_dev_regs #(
	parameter int PRESCALE = 4
) (
	input  logic                    clock_i,
	input  logic                    arst_n_i,
	input  xm23_pkg::xm23_dev_req_t req_i,
	output logic [15:0]             rdata_o,
	input  logic                    push_button_i,
	output logic [3:0]              traffic_lights_o
);
	import xm23_pkg::*;

	localparam int PW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
	localparam logic [PW-1:0] PRESC_LOAD = PW'(PRESCALE - 1);
	localparam logic [7:0] STS_MASK = (8'h01 << CSR_DBA) | (8'h01 << CSR_OF);

	logic [7:0]    tmr_csr, tmr_data, tl_csr, tl_data, pb_csr;
	logic [7:0]    tmr_csr_d, tmr_data_d, tl_csr_d, tl_data_d, pb_csr_d;
	logic [7:0]    dev_q [16];
	logic [15:0]   wr_sel;
	logic [15:0]   rd_sel;
	logic [PW-1:0] presc;
	logic          tick;
	logic          pb_meta, pb_sync, pb_prev;
	logic          pb_rise;

	// Word writes put the high byte at addr and the low byte at addr+1
	function automatic logic [7:0] wr_byte(input xm23_dev_req_t r, input logic [3:0] a);
		return (!r.byte_mode && r.addr == a) ? r.wdata[15:8] : r.wdata[7:0];
	endfunction

	// Sets DBA, or OF when DBA is still pending
	function automatic logic [7:0] post_event(input logic [7:0] csr);
		if (csr[CSR_DBA])
			csr[CSR_OF] = 1'b1;
		else
			csr[CSR_DBA] = 1'b1;
		return csr;
	endfunction

	always_comb begin
		wr_sel = '0;
		rd_sel = '0;
		wr_sel[req_i.addr] = req_i.we;
		rd_sel[req_i.addr] = req_i.rd;
		if (!req_i.byte_mode) begin
			wr_sel[req_i.addr + 4'd1] = req_i.we;
			rd_sel[req_i.addr + 4'd1] = req_i.rd;
		end
	end

	assign tick    = tmr_csr[CSR_EN] && (presc == '0);
	assign pb_rise = pb_sync && !pb_prev;

	always_comb begin
		tmr_csr_d  = tmr_csr;
		tmr_data_d = tmr_data;
		pb_csr_d   = pb_csr;
		if (rd_sel[TMR_CSR])
			tmr_csr_d = tmr_csr & ~STS_MASK;	// Read acknowledges
		if (rd_sel[PB_CSR])
			pb_csr_d = pb_csr & ~STS_MASK;
		if (tick) begin
			if (tmr_data > 8'd1) begin
				tmr_data_d = tmr_data - 8'd1;
			end else begin
				tmr_data_d = 8'h00;
				tmr_csr_d  = post_event(tmr_csr_d);
				tmr_csr_d[CSR_EN] = 1'b0;
			end
		end
		if (pb_rise)
			pb_csr_d = post_event(pb_csr_d);
		// Status bits belong to the hardware
		if (wr_sel[TMR_CSR])
			tmr_csr_d = (wr_byte(req_i, TMR_CSR) & ~STS_MASK) | (tmr_csr_d & STS_MASK);
		if (wr_sel[PB_CSR])
			pb_csr_d = (wr_byte(req_i, PB_CSR) & ~STS_MASK) | (pb_csr_d & STS_MASK);
		if (wr_sel[TMR_DATA])
			tmr_data_d = wr_byte(req_i, TMR_DATA);
		tl_csr_d  = wr_sel[TL_CSR] ? wr_byte(req_i, TL_CSR) : tl_csr;
		tl_data_d = wr_sel[TL_DATA] ? wr_byte(req_i, TL_DATA) : tl_data;
	end

	// Unnamed addresses read as zero
	always_comb begin
		for (int a = 0; a < 16; a++)
			dev_q[a] = 8'h00;
		dev_q[TMR_CSR]  = tmr_csr;
		dev_q[TMR_DATA] = tmr_data;
		dev_q[TL_CSR]   = tl_csr;
		dev_q[TL_DATA]  = tl_data;
		dev_q[PB_CSR]   = pb_csr;
		dev_q[PB_DATA]  = {7'b0, pb_sync};
	end

	assign rdata_o = req_i.byte_mode ? {8'h00, dev_q[req_i.addr]}
		: {dev_q[req_i.addr], dev_q[req_i.addr + 4'd1]};

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tmr_csr          <= '0;
			tmr_data         <= '0;
			tl_csr           <= '0;
			tl_data          <= '0;
			pb_csr           <= '0;
			presc            <= PRESC_LOAD;
			pb_meta          <= 1'b0;
			pb_sync          <= 1'b0;
			pb_prev          <= 1'b0;
			traffic_lights_o <= '0;
		end else begin
			tmr_csr  <= tmr_csr_d;
			tmr_data <= tmr_data_d;
			tl_csr   <= tl_csr_d;
			tl_data  <= tl_data_d;
			pb_csr   <= pb_csr_d;
			if (!tmr_csr[CSR_EN] || presc == '0)
				presc <= PRESC_LOAD;
			else
				presc <= presc - 1'b1;
			pb_meta <= push_button_i;	// Two-flop synchronizer
			pb_sync <= pb_meta;
			pb_prev <= pb_sync;
			traffic_lights_o <= tl_csr_d[CSR_EN] ? tl_data_d[3:0] : 4'h0;
		end
	end

	a_rd_we_excl: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		!(req_i.rd && req_i.we));

endmodule

`default_nettype wire

/* logic/xm23_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module xm23_datapath (
	input  logic                    clock_i,
	input  logic                    arst_n_i,
	input  logic                    uop_valid_i,
	input  xm23_pkg::xm23_uop_t     uop_i,
	input  logic [3:0]              rd_rnum_i,
	output logic [15:0]             rd_data_o,
	output logic [15:0]             psw_o,
	output xm23_pkg::xm23_dev_req_t dev_req_o,
	input  logic [15:0]             dev_rdata_i
);
	import xm23_pkg::*;

	// Constant registers, reached as numbers 8 to 15
	localparam logic [15:0] CONST_TBL [8] = '{
		16'h0000, 16'h0001, 16'h0002, 16'h0004,
		16'h0008, 16'h0010, 16'h0020, 16'hffff
	};

	localparam logic [15:0] RF_INIT [8] = '{
		16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0800, 16'h1000
	};

	logic [15:0] rf [8];
	logic [15:0] psw;
	logic [15:0] mar;
	logic [15:0] mdr;

	logic [15:0] src_value;
	logic [15:0] dst_value;
	logic [15:0] alu_result;
	logic [15:0] alu_psw;
	logic [15:0] bu_operand;
	logic [15:0] bu_result;
	logic        mar_in_dev;
	logic [15:0] ld_data;
	logic        rf_we;
	logic [15:0] rf_wdata;

	assign src_value = uop_i.src[3] ? CONST_TBL[uop_i.src[2:0]] : rf[uop_i.src[2:0]];
	assign dst_value = rf[uop_i.dst];
	assign rd_data_o = rd_rnum_i[3] ? CONST_TBL[rd_rnum_i[2:0]] : rf[rd_rnum_i[2:0]];
	assign psw_o     = psw;

	xm23_alu u_alu (
		.alu_op_i    (uop_i.alu_op),
		.byte_mode_i (uop_i.byte_mode),
		.dst_i       (dst_value),
		.src_i       (src_value),
		.psw_i       (psw),
		.result_o    (alu_result),
		.psw_o       (alu_psw)
	);

	// SXT works on the source, the immediate moves on the destination
	assign bu_operand = (uop_i.kind == UOP_SXT) ? src_value : dst_value;

	xm23_byte_unit u_byte_unit (
		.uop_i    (uop_i),
		.reg_i    (bu_operand),
		.result_o (bu_result)
	);

	// Only the low 16 addresses hold devices
	assign mar_in_dev = (mar[15:4] == 12'h000);
	assign ld_data    = mar_in_dev ? dev_rdata_i : 16'h0000;

	always_comb begin
		dev_req_o.rd        = uop_valid_i && (uop_i.kind == UOP_LD) && mar_in_dev;
		dev_req_o.we        = uop_valid_i && (uop_i.kind == UOP_ST) && mar_in_dev;
		dev_req_o.byte_mode = uop_i.byte_mode;
		dev_req_o.addr      = mar[3:0];
		dev_req_o.wdata     = src_value;
	end

	// Register write-back select
	always_comb begin
		rf_we    = 1'b0;
		rf_wdata = dst_value;
		if (uop_valid_i) begin
			case (uop_i.kind)
				UOP_ALU: begin
					rf_we    = (uop_i.alu_op != CMP) && (uop_i.alu_op != BIT);	// Flags only
					rf_wdata = alu_result;
				end
				UOP_MOVE: begin
					rf_we    = 1'b1;
					rf_wdata = uop_i.byte_mode ? {dst_value[15:8], src_value[7:0]} : src_value;
				end
				UOP_IMM, UOP_SXT: begin
					rf_we    = 1'b1;
					rf_wdata = bu_result;
				end
				UOP_LD: begin
					rf_we    = 1'b1;
					rf_wdata = uop_i.byte_mode ? {dst_value[15:8], ld_data[7:0]} : ld_data;
				end
				default: rf_we = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 8; i++)
				rf[i] <= RF_INIT[i];
			psw <= PSW_RESET;
			mar <= 16'h0000;
		end else begin
			if (rf_we)
				rf[uop_i.dst] <= rf_wdata;
			if (uop_valid_i && uop_i.kind == UOP_ALU)
				psw <= alu_psw;
			if (uop_valid_i && uop_i.kind == UOP_LD_MAR)
				mar <= src_value;
		end
	end

	// MDR sees load data coming in and store data going out
	always_ff @(posedge clock_i) begin
		if (uop_valid_i && uop_i.kind == UOP_LD)
			mdr <= ld_data;
		else if (uop_valid_i && uop_i.kind == UOP_ST)
			mdr <= src_value;
	end

	a_kind_known: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		uop_valid_i |-> !$isunknown(uop_i.kind));

endmodule

`default_nettype wire

/* logic/xm23_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module xm23_core_top #(
	parameter int PRESCALE = 4	// Clocks per timer count
) (
	input  logic                clock_i,
	input  logic                arst_n_i,
	input  logic                uop_valid_i,
	input  xm23_pkg::xm23_uop_t uop_i,
	input  logic [3:0]          rd_rnum_i,
	output logic [15:0]         rd_data_o,
	output logic [15:0]         psw_o,
	input  logic                push_button_i,
	output logic [3:0]          traffic_lights_o
);
	import xm23_pkg::*;

	xm23_dev_req_t dev_req;
	logic [15:0]   dev_rdata;	// Same-cycle answer from the devices

	xm23_datapath u_datapath (
		.clock_i     (clock_i),
		.arst_n_i    (arst_n_i),
		.uop_valid_i (uop_valid_i),
		.uop_i       (uop_i),
		.rd_rnum_i   (rd_rnum_i),
		.rd_data_o   (rd_data_o),
		.psw_o       (psw_o),
		.dev_req_o   (dev_req),
		.dev_rdata_i (dev_rdata)
	);

	xm23_dev_regs #(
		.PRESCALE (PRESCALE)
	) u_dev_regs (
		.clock_i          (clock_i),
		.arst_n_i         (arst_n_i),
		.req_i            (dev_req),
		.rdata_o          (dev_rdata),
		.push_button_i    (push_button_i),
		.traffic_lights_o (traffic_lights_o)
	);

endmodule

`default_nettype wire

/* testbench/tb_xm23_model.svh */
`ifndef TB_XM23_MODEL_SVH
`define TB_XM23_MODEL_SVH
`default_nettype none

	logic [31:0] lcg_state = 32'hf3d8_a52c;
	logic [15:0] shadow_rf [8];
	logic [15:0] shadow_psw;
	logic [3:0]  exp_lights;
	int          fail_count = 0;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Zero, powers of two up to 32, then all ones
	function automatic logic [15:0] const_value(input logic [2:0] idx);
		if (idx == 3'd0)
			return 16'h0000;
		if (idx == 3'd7)
			return 16'hffff;
		return 16'h0001 << (idx - 3'd1);
	endfunction

	function automatic logic [15:0] operand(input logic [3:0] rnum);
		return rnum[3] ? const_value(rnum[2:0]) : shadow_rf[rnum[2:0]];
	endfunction

	// Returns {result, new PSW}
	function automatic logic [31:0] ref_alu(input xm23_alu_op_e op, input logic bm,
		input logic [15:0] d, input logic [15:0] s, input logic [15:0] p);
		logic [15:0] mask;
		logic [16:0] sum;
		logic [15:0] r;
		logic [15:0] np;
		logic        arith;
		logic        sub;
		int          top;
		mask  = bm ? 16'h00ff : 16'hffff;
		top   = bm ? 7 : 15;
		arith = 1'b1;
		sub   = 1'b0;
		sum   = '0;
		case (op)
			ADD: sum = 17'(d & mask) + 17'(s & mask);
			ADDC: sum = 17'(d & mask) + 17'(s & mask) + 17'(p[PSW_C]);
			SUB, CMP: begin
				sum = 17'(d & mask) + 17'(~s & mask) + 17'd1;
				sub = 1'b1;
			end
			SUBC: begin
				sum = 17'(d & mask) + 17'(~s & mask) + 17'(p[PSW_C]);
				sub = 1'b1;
			end
			default: arith = 1'b0;
		endcase
		case (op)
			XOR: r = d ^ s;
			AND, BIT: r = d & s;
			OR, BIS: r = d | s;
			BIC: r = d & ~s;
			default: r = sum[15:0];
		endcase
		r = r & mask;
		np = p;
		np[PSW_Z] = (r == 16'h0000);
		np[PSW_N] = r[top];
		np[PSW_V] = 1'b0;
		if (arith) begin
			np[PSW_C] = bm ? sum[8] : sum[16];
			// Signed overflow seen from the source sign
			if (sub)
				np[PSW_V] = (d[top] != s[top]) && (r[top] != d[top]);
			else
				np[PSW_V] = (d[top] == s[top]) && (r[top] != d[top]);
		end
		return {(bm ? {d[15:8], r[7:0]} : r), np};
	endfunction

	function automatic logic [15:0] ref_imm(input xm23_imm_op_e op, input logic [15:0] v,
		input logic [7:0] b);
		case (op)
			MOVL: return {v[15:8], b};
			MOVLZ: return {8'h00, b};
			MOVLS: return {8'hff, b};
			default: return {b, v[7:0]};
		endcase
	endfunction

	// Shift the chosen bit to the top, then shift back arithmetically
	function automatic logic [15:0] ref_sxt(input logic [15:0] v, input logic [3:0] b);
		logic signed [15:0] t;
		t = v << (4'd15 - b);
		return t >>> (4'd15 - b);
	endfunction

	function automatic xm23_uop_t alu_uop(input xm23_alu_op_e op, input logic [2:0] dst,
		input logic [3:0] src, input logic bm);
		xm23_uop_t u;
		u           = '0;
		u.kind      = UOP_ALU;
		u.alu_op    = op;
		u.dst       = dst;
		u.src       = src;
		u.byte_mode = bm;
		return u;
	endfunction

	function automatic xm23_uop_t imm_uop(input xm23_imm_op_e op, input logic [2:0] dst,
		input logic [7:0] b);
		xm23_uop_t u;
		u          = '0;
		u.kind     = UOP_IMM;
		u.imm_op   = op;
		u.dst      = dst;
		u.imm_byte = b;
		return u;
	endfunction

	function automatic xm23_uop_t reg_uop(input xm23_uop_e kind, input logic [2:0] dst,
		input logic [3:0] src, input logic bm, input logic [3:0] sbit);
		xm23_uop_t u;
		u           = '0;
		u.kind      = kind;	// MOVE, SXT, LD_MAR, LD or ST
		u.dst       = dst;
		u.src       = src;
		u.byte_mode = bm;
		u.sxt_bit   = sbit;
		return u;
	endfunction

	task automatic stop_with_failure();
		fail_count = fail_count + 1;
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic abort_run(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		stop_with_failure();
	endtask

	task automatic compare_word(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

`default_nettype wire
`endif

/* testbench/tb_xm23_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_xm23_core;
	import xm23_pkg::*;

	localparam int PRESCALE   = 4;
	localparam int TMR_LIMIT  = 3 * PRESCALE + 8;
	localparam int PB_LIMIT   = 10;
	localparam int MAX_CYCLES = 4000;	// About three times the whole sequence

	logic        clock = 1'b0;
	logic        arst_n = 1'b0;
	logic        uop_valid = 1'b0;
	xm23_uop_t   uop = '0;
	logic [3:0]  rd_rnum = 4'd0;
	logic [15:0] rd_data;
	logic [15:0] psw;
	logic        push_button = 1'b0;
	logic [3:0]  traffic_lights;
	int          cycle_count = 0;
	event        req_ev;
	event        done_ev;
	logic        req_peek = 1'b0;
	logic [2:0]  peek_num = 3'd0;
	logic [15:0] peek_value;

	`include "tb_xm23_model.svh"

	xm23_core_top #(
		.PRESCALE (PRESCALE)
	) dut0 (
		.clock_i          (clock),
		.arst_n_i         (arst_n),
		.uop_valid_i      (uop_valid),
		.uop_i            (uop),
		.rd_rnum_i        (rd_rnum),
		.rd_data_o        (rd_data),
		.psw_o            (psw),
		.push_button_i    (push_button),
		.traffic_lights_o (traffic_lights)
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			abort_run("the run did not finish within the cycle limit");
	end

	// Checker walks the read port over registers and constants
	always begin
		@(req_ev);
		if (req_peek) begin
			rd_rnum = {1'b0, peek_num};
			#0.5;
			peek_value = rd_data;
		end else begin
			for (int i = 0; i < 16; i++) begin
				rd_rnum = 4'(i);
				#0.5;
				compare_word($sformatf("R%0d", i), rd_data, operand(4'(i)));
			end
			compare_word("psw_o", psw, shadow_psw);
			compare_word("traffic_lights_o", {12'h000, traffic_lights}, {12'h000, exp_lights});
		end
		-> done_ev;
	end

	task automatic check_state();
		req_peek = 1'b0;
		-> req_ev;
		@(done_ev);
	endtask

	task automatic peek_reg(input logic [2:0] n, output logic [15:0] v);
		req_peek = 1'b1;
		peek_num = n;
		-> req_ev;
		@(done_ev);
		v = peek_value;
	endtask

	// One strobe cycle, the op lands on the second edge
	task automatic apply_uop(input xm23_uop_t u);
		@(posedge clock);
		#2;
		uop_valid = 1'b1;
		uop       = u;
		@(posedge clock);
		#2;
		uop_valid = 1'b0;
		uop       = '0;
	endtask

	task automatic exec_uop(input xm23_uop_t u, input logic [15:0] ld_value);
		logic [31:0] alu_res;
		logic [15:0] src_val;
		logic [15:0] dst_next;
		logic [15:0] psw_next;
		logic        wr;
		src_val  = operand(u.src);
		dst_next = shadow_rf[u.dst];
		psw_next = shadow_psw;
		wr       = 1'b1;
		case (u.kind)
			UOP_ALU: begin
				alu_res  = ref_alu(u.alu_op, u.byte_mode, dst_next, src_val, shadow_psw);
				wr       = (u.alu_op != CMP) && (u.alu_op != BIT);
				dst_next = alu_res[31:16];
				psw_next = alu_res[15:0];
			end
			UOP_MOVE: dst_next = u.byte_mode ? {dst_next[15:8], src_val[7:0]} : src_val;
			UOP_IMM: dst_next = ref_imm(u.imm_op, dst_next, u.imm_byte);
			UOP_SXT: dst_next = ref_sxt(src_val, u.sxt_bit);
			UOP_LD: dst_next = u.byte_mode ? {dst_next[15:8], ld_value[7:0]} : ld_value;
			default: wr = 1'b0;
		endcase
		apply_uop(u);
		if (wr)
			shadow_rf[u.dst] = dst_next;
		shadow_psw = psw_next;
		check_state();
	endtask

	task automatic set_reg(input logic [2:0] n, input logic [15:0] v);
		exec_uop(imm_uop(MOVLZ, n, v[7:0]), 16'h0000);
		exec_uop(imm_uop(MOVH, n, v[15:8]), 16'h0000);
	endtask

	task automatic set_mar(input logic [3:0] src);
		exec_uop(reg_uop(UOP_LD_MAR, 3'd0, src, 1'b0, 4'd0), 16'h0000);
	endtask

	task automatic store(input logic [3:0] src, input logic bm);
		exec_uop(reg_uop(UOP_ST, 3'd0, src, bm, 4'd0), 16'h0000);
	endtask

	task automatic load_expect(input logic [2:0] dst, input logic bm, input logic [15:0] v);
		exec_uop(reg_uop(UOP_LD, dst, 4'd0, bm, 4'd0), v);
	endtask

	// Counting shows EN alone, expiry shows DBA alone
	task automatic wait_timer_expiry(input int start);
		logic [15:0] seen;
		logic        done;
		done = 1'b0;
		while (!done) begin
			if (cycle_count - start > TMR_LIMIT)
				abort_run("timer DBA did not appear in time");
			apply_uop(reg_uop(UOP_LD, 3'd0, 4'd0, 1'b1, 4'd0));
			peek_reg(3'd0, seen);
			done = seen[CSR_DBA];
			shadow_rf[0] = {shadow_rf[0][15:8], (done ? 8'h04 : 8'h01)};
			check_state();
		end
	endtask

	// Word read of PB_CSR and PB_DATA together
	task automatic wait_button_event(input int start);
		logic [15:0] seen;
		logic        done;
		done = 1'b0;
		while (!done) begin
			if (cycle_count - start > PB_LIMIT)
				abort_run("push-button DBA did not appear in time");
			apply_uop(reg_uop(UOP_LD, 3'd0, 4'd0, 1'b0, 4'd0));
			peek_reg(3'd0, seen);
			done = seen[8 + CSR_DBA];
			shadow_rf[0] = done ? 16'h0401 : (seen[0] ? 16'h0001 : 16'h0000);
			check_state();
		end
	endtask

	initial begin
		logic [31:0] r;
		int          start;
		for (int i = 0; i < 8; i++)
			shadow_rf[i] = 16'h0000;
		shadow_rf[6] = 16'h0800;
		shadow_rf[7] = 16'h1000;
		shadow_psw   = 16'h60e0;
		exp_lights   = 4'h0;
		repeat (2) @(posedge clock);
		#2;
		arst_n = 1'b1;
		check_state();	// Reset values

		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			set_reg(3'(i), r[31:16]);
		end
		repeat (300) begin
			r = next_rand();
			exec_uop(alu_uop(xm23_alu_op_e'(4'(r[22:12] % 11)), r[30:28], r[27:24], r[23]),
				16'h0000);
		end

		repeat (150) begin
			r = next_rand();
			case (r[31:30])
				2'd0: exec_uop(imm_uop(xm23_imm_op_e'(r[29:28]), r[27:25], r[23:16]), 16'h0);
				2'd1: exec_uop(reg_uop(UOP_SXT, r[27:25], r[24:21], 1'b0, r[19:16]), 16'h0);
				default: exec_uop(reg_uop(UOP_MOVE, r[27:25], r[24:21], r[20], 4'd0), 16'h0);
			endcase
		end

		// Word at TL_CSR puts the high byte in TL_CSR
		set_reg(3'd1, 16'h01a9);
		set_reg(3'd2, 16'h0006);
		set_mar(4'd2);
		exp_lights = 4'h9;
		store(4'd1, 1'b0);
		load_expect(3'd3, 1'b0, 16'h01a9);
		set_reg(3'd2, 16'h0007);
		set_mar(4'd2);
		load_expect(3'd4, 1'b1, 16'h00a9);
		set_reg(3'd1, 16'h5a3c);
		exp_lights = 4'hc;
		store(4'd1, 1'b1);
		load_expect(3'd4, 1'b1, 16'h003c);
		set_reg(3'd2, 16'h0006);
		set_mar(4'd2);
		exp_lights = 4'h0;
		store(4'd8, 1'b1);	// Constant 0 clears EN
		set_reg(3'd2, 16'h0007);
		set_mar(4'd2);
		load_expect(3'd5, 1'b1, 16'h003c);
		set_reg(3'd1, 16'h7e21);
		set_mar(4'd9);
		store(4'd1, 1'b0);
		load_expect(3'd3, 1'b0, 16'h7e00);
		store(4'd1, 1'b1);
		load_expect(3'd3, 1'b1, 16'h0021);
		set_reg(3'd2, 16'h0028);
		set_mar(4'd2);
		load_expect(3'd3, 1'b0, 16'h0000);

		exec_uop(imm_uop(MOVLZ, 3'd0, 8'h00), 16'h0000);
		set_reg(3'd1, 16'h0003);
		set_mar(4'd9);
		store(4'd1, 1'b1);
		set_mar(4'd8);
		store(4'd9, 1'b1);	// Constant 1 sets EN
		start = cycle_count;
		wait_timer_expiry(start);
		if (cycle_count - start > TMR_LIMIT)
			abort_run("timer DBA came later than the allowed latency");
		set_mar(4'd9);
		load_expect(3'd0, 1'b1, 16'h0000);
		set_mar(4'd8);
		load_expect(3'd0, 1'b1, 16'h0000);
		repeat (2) begin
			set_mar(4'd9);
			store(4'd1, 1'b1);
			set_mar(4'd8);
			store(4'd9, 1'b1);
			repeat (TMR_LIMIT) @(posedge clock);
		end
		load_expect(3'd0, 1'b1, 16'h000c);
		load_expect(3'd0, 1'b1, 16'h0000);

		set_mar(4'd12);
		@(posedge clock);
		#2;
		push_button = 1'b1;
		start = cycle_count;
		wait_button_event(start);
		load_expect(3'd0, 1'b0, 16'h0001);

		if (fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+testbench
logic/xm23_pkg.sv
logic/xm23_alu.sv
logic/xm23_byte_unit.sv
logic/xm23_dev_regs.sv
logic/xm23_datapath.sv
logic/xm23_core_top.sv
testbench/tb_xm23_core.sv

/* Bender.yml */
package:
  name: xm23_core

sources:
  - logic/xm23_pkg.sv
  - logic/xm23_alu.sv
  - logic/xm23_byte_unit.sv
  - logic/xm23_dev_regs.sv
  - logic/xm23_datapath.sv
  - logic/xm23_core_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_xm23_core.sv
